//--- src/csr_pkg.sv
// Shared definitions of the machine-mode CSR block
// Widths, CSR addresses, field offsets, command codes and the structs
// that run between the access decoder, the trap logic and the counters

package csr_pkg;

    localparam int xlen           = 32;
    localparam int csr_addr_width = 12;
    localparam int cnt_width      = 64;

    // CSR addresses ---------------
    localparam logic [csr_addr_width-1:0] csr_addr_mvendorid = 12'hF11;
    localparam logic [csr_addr_width-1:0] csr_addr_marchid   = 12'hF12;
    localparam logic [csr_addr_width-1:0] csr_addr_mimpid    = 12'hF13;
    localparam logic [csr_addr_width-1:0] csr_addr_mhartid   = 12'hF14;
    localparam logic [csr_addr_width-1:0] csr_addr_mstatus   = 12'h300;
    localparam logic [csr_addr_width-1:0] csr_addr_misa      = 12'h301;
    localparam logic [csr_addr_width-1:0] csr_addr_mie       = 12'h304;
    localparam logic [csr_addr_width-1:0] csr_addr_mtvec     = 12'h305;
    localparam logic [csr_addr_width-1:0] csr_addr_mscratch  = 12'h340;
    localparam logic [csr_addr_width-1:0] csr_addr_mepc      = 12'h341;
    localparam logic [csr_addr_width-1:0] csr_addr_mcause    = 12'h342;
    localparam logic [csr_addr_width-1:0] csr_addr_mtval     = 12'h343;
    localparam logic [csr_addr_width-1:0] csr_addr_mip       = 12'h344;
    localparam logic [csr_addr_width-1:0] csr_addr_cycle     = 12'hC00; // Read-only user views
    localparam logic [csr_addr_width-1:0] csr_addr_instret   = 12'hC02;
    localparam logic [csr_addr_width-1:0] csr_addr_cycleh    = 12'hC80;
    localparam logic [csr_addr_width-1:0] csr_addr_instreth  = 12'hC82;
    localparam logic [csr_addr_width-1:0] csr_addr_mcycle    = 12'hB00; // Machine views
    localparam logic [csr_addr_width-1:0] csr_addr_minstret  = 12'hB02;
    localparam logic [csr_addr_width-1:0] csr_addr_mcycleh   = 12'hB80;
    localparam logic [csr_addr_width-1:0] csr_addr_minstreth = 12'hB82;

    // Identity values
    localparam logic [xlen-1:0] csr_mvendorid = 32'h0000_0000;
    localparam logic [xlen-1:0] csr_marchid   = 32'h0000_0000;
    localparam logic [xlen-1:0] csr_mimpid    = 32'h0000_0001;
    localparam logic [xlen-1:0] csr_misa      = 32'h4000_1100; // RV32IM

    // Field offsets ---------------
    localparam int csr_mstatus_mie_offset  = 3;
    localparam int csr_mstatus_mpie_offset = 7;
    localparam int csr_mstatus_mpp_offset  = 11;
    localparam logic [1:0] csr_mstatus_mpp = 2'b11; // Always machine mode
    localparam int csr_mie_msie_offset     = 3; // Shared by mie and mip
    localparam int csr_mie_mtie_offset     = 7;
    localparam int csr_mie_meie_offset     = 11;

    // Reset values
    localparam logic csr_mstatus_mie_rst_val  = 1'b0;
    localparam logic csr_mstatus_mpie_rst_val = 1'b1;
    localparam logic csr_mie_rst_val          = 1'b0;

    typedef enum logic [1:0] {
        csr_cmd_none  = 2'd0,
        csr_cmd_write = 2'd1,
        csr_cmd_set   = 2'd2,
        csr_cmd_clear = 2'd3
    } csr_cmd_e;

    typedef logic [3:0] exc_code_t;

    localparam exc_code_t exc_code_reset          = 4'd0;
    localparam exc_code_t exc_code_irq_m_software = 4'd3;
    localparam exc_code_t exc_code_irq_m_timer    = 4'd7;
    localparam exc_code_t exc_code_irq_m_external = 4'd11;

    typedef struct packed {
        logic            mstatus_up;
        logic            mie_up;
        logic            mepc_up;
        logic            mcause_up;
        logic            mtval_up;
        logic [1:0]      cycle_up;   // Bit 0 low half, bit 1 high half
        logic [1:0]      instret_up;
        logic [xlen-1:0] w_data;     // Merged write data
    } csr_wr_t;

    typedef struct packed {
        logic            mstatus_mie;
        logic            mstatus_mpie;
        logic            mie_msie;
        logic            mie_mtie;
        logic            mie_meie;
        logic            mip_msip;
        logic            mip_mtip;
        logic            mip_meip;
        logic [xlen-1:0] mepc;
        logic            mcause_i;
        exc_code_t       mcause_ec;
        logic [xlen-1:0] mtval;
    } csr_trap_state_t;

    typedef struct packed {
        logic            take_irq;
        logic            take_exc;
        logic            mret_update;
        logic            mret_instr;
        exc_code_t       exc_code;
        logic [xlen-1:0] trap_val;
    } csr_event_t;

endpackage

//--- src/csr_access.sv
// Execute-stage CSR access with address decode, read mux and write merge
// Produces one update strobe per register for the trap logic and the
// counters, and holds mscratch locally

module csr_access #(
    parameter logic [csr_pkg::xlen-1:0] mtvec_base = 32'h0000_0200
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                r_req,
    input  logic                                w_req,
    input  logic [csr_pkg::csr_addr_width-1:0]  rw_addr,
    input  csr_pkg::csr_cmd_e                   w_cmd,
    input  logic [csr_pkg::xlen-1:0]            w_data,
    input  logic [csr_pkg::xlen-1:0]            fuse_mhartid,
    input  csr_pkg::csr_trap_state_t            trap_state,
    input  logic [csr_pkg::cnt_width-1:0]       cycle,
    input  logic [csr_pkg::cnt_width-1:0]       instret,
    output logic [csr_pkg::xlen-1:0]            r_data,
    output logic                                rw_exc,
    output csr_pkg::csr_wr_t                    wr
);

    import csr_pkg::*;

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mie;
    logic [xlen-1:0] mip;
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] w_merged;
    logic            mscratch_up;
    logic            r_exc;
    logic            w_exc;

    // Read path ------------------------
    always_comb begin
        mstatus = '0;
        mie     = '0;
        mip     = '0;
        mstatus[csr_mstatus_mie_offset]  = trap_state.mstatus_mie;
        mstatus[csr_mstatus_mpie_offset] = trap_state.mstatus_mpie;
        mstatus[csr_mstatus_mpp_offset+1:csr_mstatus_mpp_offset] = csr_mstatus_mpp;
        mie[csr_mie_msie_offset] = trap_state.mie_msie;
        mie[csr_mie_mtie_offset] = trap_state.mie_mtie;
        mie[csr_mie_meie_offset] = trap_state.mie_meie;
        mip[csr_mie_msie_offset] = trap_state.mip_msip;
        mip[csr_mie_mtie_offset] = trap_state.mip_mtip;
        mip[csr_mie_meie_offset] = trap_state.mip_meip;
    end

    always_comb begin
        r_data = '0;
        r_exc  = 1'b0;
        case (rw_addr)
            csr_addr_mvendorid : r_data = csr_mvendorid;
            csr_addr_marchid   : r_data = csr_marchid;
            csr_addr_mimpid    : r_data = csr_mimpid;
            csr_addr_mhartid   : r_data = fuse_mhartid;
            csr_addr_mstatus   : r_data = mstatus;
            csr_addr_misa      : r_data = csr_misa;
            csr_addr_mie       : r_data = mie;
            csr_addr_mtvec     : r_data = mtvec_base; // Direct mode only
            csr_addr_mscratch  : r_data = mscratch;
            csr_addr_mepc      : r_data = trap_state.mepc;
            csr_addr_mcause    : r_data = {trap_state.mcause_i,
                                           {(xlen-1-$bits(exc_code_t)){1'b0}},
                                           trap_state.mcause_ec};
            csr_addr_mtval     : r_data = trap_state.mtval;
            csr_addr_mip       : r_data = mip;
            csr_addr_cycle,
            csr_addr_mcycle    : r_data = cycle[xlen-1:0];
            csr_addr_cycleh,
            csr_addr_mcycleh   : r_data = cycle[cnt_width-1:xlen];
            csr_addr_instret,
            csr_addr_minstret  : r_data = instret[xlen-1:0];
            csr_addr_instreth,
            csr_addr_minstreth : r_data = instret[cnt_width-1:xlen];
            default            : r_exc  = r_req; // Not implemented
        endcase
    end

    // Write path -----------------------
    always_comb begin
        case (w_cmd)
            csr_cmd_write : w_merged = w_data;
            csr_cmd_set   : w_merged = w_data | r_data;
            csr_cmd_clear : w_merged = ~w_data & r_data;
            default       : w_merged = '0;
        endcase
    end

    always_comb begin
        wr          = '0;
        wr.w_data   = w_merged;
        mscratch_up = 1'b0;
        w_exc       = 1'b0;
        if (w_req) begin
            case (rw_addr)
                csr_addr_mstatus   : wr.mstatus_up    = 1'b1;
                csr_addr_mie       : wr.mie_up        = 1'b1;
                csr_addr_mscratch  : mscratch_up      = 1'b1;
                csr_addr_mepc      : wr.mepc_up       = 1'b1;
                csr_addr_mcause    : wr.mcause_up     = 1'b1;
                csr_addr_mtval     : wr.mtval_up      = 1'b1;
                csr_addr_mcycle    : wr.cycle_up[0]   = 1'b1;
                csr_addr_mcycleh   : wr.cycle_up[1]   = 1'b1;
                csr_addr_minstret  : wr.instret_up[0] = 1'b1;
                csr_addr_minstreth : wr.instret_up[1] = 1'b1;
                csr_addr_misa,
                csr_addr_mtvec,
                csr_addr_mip       : begin end // Silently ignored
                default            : w_exc = 1'b1; // Read-only or unknown
            endcase
        end
    end

    assign rw_exc = r_exc | w_exc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mscratch <= '0;
        end else if (mscratch_up) begin
            mscratch <= w_merged;
        end
    end

endmodule

//--- src/csr_trap.sv
// Machine trap registers and interrupt logic
// Applies trap events and CSR write strobes to mstatus, mie, mepc, mcause
// and mtval, and drives the interrupt request and the new program counter

module csr_trap #(
    parameter logic [csr_pkg::xlen-1:0] mtvec_base = 32'h0000_0200
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  csr_pkg::csr_wr_t            wr,
    input  csr_pkg::csr_event_t         evt,
    input  logic [csr_pkg::xlen-1:0]    curr_pc,
    input  logic [csr_pkg::xlen-1:0]    next_pc,
    input  logic                        ext_irq,
    input  logic                        soft_irq,
    input  logic                        timer_irq,
    output csr_pkg::csr_trap_state_t    trap_state,
    output logic [csr_pkg::xlen-1:0]    new_pc,
    output logic                        irq,
    output logic                        ip_ie,
    output logic                        mstatus_mie_up
);

    import csr_pkg::*;

    logic              mstatus_mie;
    logic              mstatus_mpie;
    logic              mie_msie;
    logic              mie_mtie;
    logic              mie_meie;
    logic [xlen-1:2]   mepc;       // Word aligned
    logic              mcause_i;
    exc_code_t         mcause_ec;
    exc_code_t         mcause_ec_new;
    logic [xlen-1:0]   mtval;
    logic              e_exc;
    logic              e_irq;
    logic              e_mret;

    // Event priority -------------------
    assign e_exc  = evt.take_exc;
    assign e_irq  = evt.take_irq & ~evt.take_exc; // Exception wins
    assign e_mret = evt.mret_update;

    // Highest pending enabled source
    always_comb begin
        if (ext_irq & mie_meie) begin
            mcause_ec_new = exc_code_irq_m_external;
        end else if (soft_irq & mie_msie) begin
            mcause_ec_new = exc_code_irq_m_software;
        end else if (timer_irq & mie_mtie) begin
            mcause_ec_new = exc_code_irq_m_timer;
        end else begin
            mcause_ec_new = exc_code_irq_m_external;
        end
    end

    // Registers ------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_mie  <= csr_mstatus_mie_rst_val;
            mstatus_mpie <= csr_mstatus_mpie_rst_val;
        end else if (e_exc | e_irq) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= mstatus_mie;
        end else if (e_mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else if (wr.mstatus_up) begin
            mstatus_mie  <= wr.w_data[csr_mstatus_mie_offset];
            mstatus_mpie <= wr.w_data[csr_mstatus_mpie_offset];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mie_msie <= csr_mie_rst_val;
            mie_mtie <= csr_mie_rst_val;
            mie_meie <= csr_mie_rst_val;
        end else if (wr.mie_up) begin
            mie_msie <= wr.w_data[csr_mie_msie_offset];
            mie_mtie <= wr.w_data[csr_mie_mtie_offset];
            mie_meie <= wr.w_data[csr_mie_meie_offset];
        end
    end

    always_ff @(posedge clk) begin
        if (e_exc) begin
            mepc <= curr_pc[xlen-1:2];
        end else if (e_irq & ~evt.mret_instr) begin
            mepc <= next_pc[xlen-1:2]; // Resume after the interrupted instruction
        end else if (wr.mepc_up) begin
            mepc <= wr.w_data[xlen-1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcause_i  <= 1'b0;
            mcause_ec <= exc_code_reset;
        end else if (e_exc) begin
            mcause_i  <= 1'b0;
            mcause_ec <= evt.exc_code;
        end else if (e_irq) begin
            mcause_i  <= 1'b1;
            mcause_ec <= mcause_ec_new;
        end else if (wr.mcause_up) begin
            mcause_i  <= wr.w_data[xlen-1];
            mcause_ec <= wr.w_data[$bits(exc_code_t)-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (e_exc) begin
            mtval <= evt.trap_val;
        end else if (e_irq) begin
            mtval <= '0;
        end else if (wr.mtval_up) begin
            mtval <= wr.w_data;
        end
    end

    // Outputs --------------------------
    assign ip_ie = (ext_irq & mie_meie) | (soft_irq & mie_msie) | (timer_irq & mie_mtie);
    assign irq   = ip_ie & mstatus_mie;

    assign new_pc = (evt.mret_instr & ~e_irq) ? {mepc, 2'b00} : mtvec_base;

    assign mstatus_mie_up = wr.mstatus_up | wr.mie_up | e_mret;

    always_comb begin
        trap_state.mstatus_mie  = mstatus_mie;
        trap_state.mstatus_mpie = mstatus_mpie;
        trap_state.mie_msie     = mie_msie;
        trap_state.mie_mtie     = mie_mtie;
        trap_state.mie_meie     = mie_meie;
        trap_state.mip_msip     = soft_irq;
        trap_state.mip_mtip     = timer_irq;
        trap_state.mip_meip     = ext_irq;
        trap_state.mepc         = {mepc, 2'b00};
        trap_state.mcause_i     = mcause_i;
        trap_state.mcause_ec    = mcause_ec;
        trap_state.mtval        = mtval;
    end

endmodule

//--- src/csr_counter.sv
// 64-bit event counter with separate low and high half writes
// Used for both the cycle and the instret counters

module csr_counter (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            inc,
    input  logic [1:0]                      up,     // Bit 0 low, bit 1 high
    input  logic [csr_pkg::xlen-1:0]        w_data,
    output logic [csr_pkg::cnt_width-1:0]   count
);

    import csr_pkg::*;

    logic [cnt_width-1:0] count_next;

    // A half write replaces that half of the incremented value
    always_comb begin
        count_next = count + {{(cnt_width-1){1'b0}}, inc};
        if (up[0]) begin
            count_next[xlen-1:0] = w_data;
        end
        if (up[1]) begin
            count_next[cnt_width-1:xlen] = w_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

//--- src/csr_unit.sv
// Machine-mode CSR block of the core, seen from the execute stage
// Connects the access decoder, the trap logic and the cycle and instret
// counters; mtvec_base sets the trap vector

module csr_unit #(
    parameter logic [csr_pkg::xlen-1:0] mtvec_base = 32'h0000_0200
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                r_req,
    input  logic                                w_req,
    input  logic [csr_pkg::csr_addr_width-1:0]  rw_addr,
    input  csr_pkg::csr_cmd_e                   w_cmd,
    input  logic [csr_pkg::xlen-1:0]            w_data,
    input  csr_pkg::csr_event_t                 evt,
    input  logic [csr_pkg::xlen-1:0]            curr_pc,
    input  logic [csr_pkg::xlen-1:0]            next_pc,
    input  logic                                instret_nexc, // Retired without exception
    input  logic                                ext_irq,
    input  logic                                soft_irq,
    input  logic                                timer_irq,
    input  logic [csr_pkg::xlen-1:0]            fuse_mhartid,
    output logic [csr_pkg::xlen-1:0]            r_data,
    output logic                                rw_exc,
    output logic [csr_pkg::xlen-1:0]            new_pc,
    output logic                                irq,
    output logic                                ip_ie,
    output logic                                mstatus_mie_up
);

    import csr_pkg::*;

    csr_wr_t              wr;
    csr_trap_state_t      trap_state;
    logic [cnt_width-1:0] cycle;
    logic [cnt_width-1:0] instret;

    csr_access #(
        .mtvec_base (mtvec_base)
    ) i_access (
        .clk          (clk),
        .rst_n        (rst_n),
        .r_req        (r_req),
        .w_req        (w_req),
        .rw_addr      (rw_addr),
        .w_cmd        (w_cmd),
        .w_data       (w_data),
        .fuse_mhartid (fuse_mhartid),
        .trap_state   (trap_state),
        .cycle        (cycle),
        .instret      (instret),
        .r_data       (r_data),
        .rw_exc       (rw_exc),
        .wr           (wr)
    );

    csr_trap #(
        .mtvec_base (mtvec_base)
    ) i_trap (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr             (wr),
        .evt            (evt),
        .curr_pc        (curr_pc),
        .next_pc        (next_pc),
        .ext_irq        (ext_irq),
        .soft_irq       (soft_irq),
        .timer_irq      (timer_irq),
        .trap_state     (trap_state),
        .new_pc         (new_pc),
        .irq            (irq),
        .ip_ie          (ip_ie),
        .mstatus_mie_up (mstatus_mie_up)
    );

    // Cycle counts every clock
    csr_counter i_cycle (
        .clk    (clk),
        .rst_n  (rst_n),
        .inc    (1'b1),
        .up     (wr.cycle_up),
        .w_data (wr.w_data),
        .count  (cycle)
    );

    csr_counter i_instret (
        .clk    (clk),
        .rst_n  (rst_n),
        .inc    (instret_nexc),
        .up     (wr.instret_up),
        .w_data (wr.w_data),
        .count  (instret)
    );

endmodule

//--- sim/tb_csr_unit.sv
// Directed testbench for the machine-mode CSR block
// Runs reset, access, trap, interrupt, mret and counter tests against
// csr_unit and prints the error counts at the end of the run

module tb_csr_unit;

    import csr_pkg::*;

    localparam logic [xlen-1:0] mtvec_base       = 32'h0000_1000; // Non-default vector
    localparam logic [xlen-1:0] mstatus_mpp_bits = 32'h0000_1800;
    localparam logic [xlen-1:0] mie_mask         = 32'h0000_0888; // msie, mtie, meie
    localparam logic [csr_addr_width-1:0] addr_unknown = 12'h7C0;
    localparam int irq_timeout = 10;

    logic                      clk;
    logic                      rst_n;
    logic                      r_req;
    logic                      w_req;
    logic [csr_addr_width-1:0] rw_addr;
    csr_cmd_e                  w_cmd;
    logic [xlen-1:0]           w_data;
    csr_event_t                evt;
    logic [xlen-1:0]           curr_pc;
    logic [xlen-1:0]           next_pc;
    logic                      instret_nexc;
    logic                      ext_irq;
    logic                      soft_irq;
    logic                      timer_irq;
    logic [xlen-1:0]           fuse_mhartid;
    logic [xlen-1:0]           r_data;
    logic                      rw_exc;
    logic [xlen-1:0]           new_pc;
    logic                      irq;
    logic                      ip_ie;
    logic                      mstatus_mie_up;

    logic [31:0] lfsr_state;
    logic [31:0] irq_epc;
    int          mismatches;
    int          failures;

    csr_unit #(
        .mtvec_base (mtvec_base)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .r_req          (r_req),
        .w_req          (w_req),
        .rw_addr        (rw_addr),
        .w_cmd          (w_cmd),
        .w_data         (w_data),
        .evt            (evt),
        .curr_pc        (curr_pc),
        .next_pc        (next_pc),
        .instret_nexc   (instret_nexc),
        .ext_irq        (ext_irq),
        .soft_irq       (soft_irq),
        .timer_irq      (timer_irq),
        .fuse_mhartid   (fuse_mhartid),
        .r_data         (r_data),
        .rw_exc         (rw_exc),
        .new_pc         (new_pc),
        .irq            (irq),
        .ip_ie          (ip_ie),
        .mstatus_mie_up (mstatus_mie_up)
    );

    always #50 clk = ~clk;

    // Helpers ----------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
    endfunction

    task automatic next_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic next_random(output logic [31:0] v);
        logic b;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            next_bit(b);
            v = {v[30:0], b};
        end
    endtask

    // Expected result of a write command on the old contents
    function automatic logic [31:0] merge_value(input csr_cmd_e cmd, input logic [31:0] old_v,
                                                input logic [31:0] data);
        case (cmd)
            csr_cmd_write : return data;
            csr_cmd_set   : return old_v | data;
            csr_cmd_clear : return old_v & ~data;
            default       : return '0;
        endcase
    endfunction

    task automatic check_value(input string msg, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at time %0t: %s: got %h, expected %h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    // Next cycle with all strobes idle
    task automatic next_cycle();
        @(posedge clk);
        #10;
        r_req        = 1'b0;
        w_req        = 1'b0;
        w_cmd        = csr_cmd_none;
        evt          = '0;
        instret_nexc = 1'b0;
    endtask

    task automatic csr_read(input logic [csr_addr_width-1:0] addr, input logic [31:0] exp,
                            input logic exp_exc, input string msg);
        next_cycle();
        r_req   = 1'b1;
        rw_addr = addr;
        #30;
        check_value({msg, " data"}, r_data, exp);
        check_value({msg, " rw_exc"}, rw_exc, exp_exc);
    endtask

    task automatic read_value(input logic [csr_addr_width-1:0] addr, output logic [31:0] v);
        next_cycle();
        r_req   = 1'b1;
        rw_addr = addr;
        #30;
        v = r_data;
        check_value("counter read rw_exc", rw_exc, 1'b0);
    endtask

    task automatic csr_write(input logic [csr_addr_width-1:0] addr, input csr_cmd_e cmd,
                             input logic [31:0] data, input logic exp_exc, input string msg);
        next_cycle();
        w_req   = 1'b1;
        rw_addr = addr;
        w_cmd   = cmd;
        w_data  = data;
        #30;
        check_value({msg, " rw_exc"}, rw_exc, exp_exc);
    endtask

    task automatic drive_event(input logic exc, input logic irq_ev, input logic mret_up,
                               input logic mret_in, input exc_code_t code,
                               input logic [31:0] tval, input logic [31:0] pc,
                               input logic [31:0] exp_pc, input string msg);
        next_cycle();
        evt.take_exc    = exc;
        evt.take_irq    = irq_ev;
        evt.mret_update = mret_up;
        evt.mret_instr  = mret_in;
        evt.exc_code    = code;
        evt.trap_val    = tval;
        curr_pc         = pc;
        next_pc         = pc + 32'd4;
        #30;
        check_value(msg, new_pc, exp_pc);
    endtask

    task automatic wait_for_irq();
        int n;
        n = 0;
        while (irq !== 1'b1 && n < irq_timeout) begin
            @(posedge clk);
            #40;
            n++;
        end
        assert (irq === 1'b1) else begin
            $display("Timeout: irq did not rise within %0d cycles", irq_timeout);
            failures++;
        end
    endtask

    // Tests ------------------------
    task automatic test_reset();
        csr_read(csr_addr_mvendorid, csr_mvendorid, 1'b0, "mvendorid");
        csr_read(csr_addr_marchid, csr_marchid, 1'b0, "marchid");
        csr_read(csr_addr_mimpid, csr_mimpid, 1'b0, "mimpid");
        csr_read(csr_addr_misa, csr_misa, 1'b0, "misa");
        csr_read(csr_addr_mhartid, fuse_mhartid, 1'b0, "mhartid");
        csr_read(csr_addr_mstatus, mstatus_mpp_bits | 32'h80, 1'b0, "mstatus after reset");
        csr_read(csr_addr_mie, 32'h0, 1'b0, "mie after reset");
        csr_read(csr_addr_mcause, 32'h0, 1'b0, "mcause after reset");
        csr_read(csr_addr_mtvec, mtvec_base, 1'b0, "mtvec");
        next_cycle();
        #30;
        check_value("irq after reset", irq, 1'b0);
        check_value("mstatus_mie_up after reset", mstatus_mie_up, 1'b0);
        check_value("rw_exc when idle", rw_exc, 1'b0);
    endtask

    task automatic test_access();
        logic [31:0] v;
        logic [31:0] scratch_model;
        logic [31:0] mie_model;
        csr_cmd_e    cmds[3];
        cmds          = '{csr_cmd_write, csr_cmd_set, csr_cmd_clear};
        scratch_model = '0;
        mie_model     = '0;
        csr_read(csr_addr_mscratch, scratch_model, 1'b0, "mscratch after reset");
        foreach (cmds[i]) begin
            next_random(v);
            csr_write(csr_addr_mscratch, cmds[i], v, 1'b0, "mscratch write");
            scratch_model = merge_value(cmds[i], scratch_model, v);
            csr_read(csr_addr_mscratch, scratch_model, 1'b0, "mscratch readback");
        end
        foreach (cmds[i]) begin
            next_random(v);
            csr_write(csr_addr_mie, cmds[i], v, 1'b0, "mie write");
            mie_model = merge_value(cmds[i], mie_model, v) & mie_mask; // Only enables stick
            csr_read(csr_addr_mie, mie_model, 1'b0, "mie readback");
        end
        csr_read(addr_unknown, 32'h0, 1'b1, "unknown address read");
        csr_write(addr_unknown, csr_cmd_write, v, 1'b1, "unknown address write");
        csr_write(csr_addr_cycle, csr_cmd_write, v, 1'b1, "user cycle write");
        csr_write(csr_addr_misa, csr_cmd_write, 32'h0, 1'b0, "misa write");
        csr_read(csr_addr_misa, csr_misa, 1'b0, "misa after write");
        csr_write(csr_addr_mie, csr_cmd_write, 32'h0, 1'b0, "mie restore");
    endtask

    task automatic test_exception();
        logic [31:0] pc;
        logic [31:0] tval;
        csr_write(csr_addr_mstatus, csr_cmd_write, 32'h8, 1'b0, "mstatus mie on");
        csr_read(csr_addr_mstatus, mstatus_mpp_bits | 32'h8, 1'b0, "mstatus before exception");
        next_random(pc);
        pc[1:0] = 2'b00;
        next_random(tval);
        drive_event(1'b1, 1'b0, 1'b0, 1'b0, 4'd5, tval, pc, mtvec_base, "exception new_pc");
        csr_read(csr_addr_mepc, pc, 1'b0, "exception mepc");
        csr_read(csr_addr_mcause, 32'h5, 1'b0, "exception mcause");
        csr_read(csr_addr_mtval, tval, 1'b0, "exception mtval");
        csr_read(csr_addr_mstatus, mstatus_mpp_bits | 32'h80, 1'b0, "mstatus after exception");
        // Exception and interrupt together
        next_random(pc);
        pc[1:0] = 2'b00;
        next_random(tval);
        drive_event(1'b1, 1'b1, 1'b0, 1'b0, 4'd2, tval, pc, mtvec_base, "exc with irq new_pc");
        csr_read(csr_addr_mepc, pc, 1'b0, "exc with irq mepc");
        csr_read(csr_addr_mcause, 32'h2, 1'b0, "exc with irq mcause");
        csr_read(csr_addr_mtval, tval, 1'b0, "exc with irq mtval");
        csr_read(csr_addr_mstatus, mstatus_mpp_bits, 1'b0, "mstatus after exc with irq");
    endtask

    task automatic test_interrupt(output logic [31:0] epc);
        logic [31:0] pc;
        logic [31:0] tval;
        csr_write(csr_addr_mie, csr_cmd_write, mie_mask, 1'b0, "mie enable all");
        csr_write(csr_addr_mstatus, csr_cmd_write, 32'h8, 1'b0, "mstatus mie on");
        next_cycle();
        ext_irq   = 1'b1;
        timer_irq = 1'b1;
        #30;
        wait_for_irq();
        check_value("ip_ie with sources", ip_ie, 1'b1);
        check_value("irq with sources", irq, 1'b1);
        next_random(pc);
        pc[1:0] = 2'b00;
        next_random(tval);
        drive_event(1'b0, 1'b1, 1'b0, 1'b0, 4'd0, tval, pc, mtvec_base, "interrupt new_pc");
        epc = pc + 32'd4;
        csr_read(csr_addr_mcause, 32'h8000_000B, 1'b0, "interrupt mcause");
        csr_read(csr_addr_mepc, epc, 1'b0, "interrupt mepc");
        csr_read(csr_addr_mtval, 32'h0, 1'b0, "interrupt mtval");
        check_value("irq with mstatus mie clear", irq, 1'b0);
        check_value("ip_ie with mstatus mie clear", ip_ie, 1'b1);
        next_cycle();
        ext_irq   = 1'b0;
        timer_irq = 1'b0;
    endtask

    task automatic test_mret(input logic [31:0] epc);
        drive_event(1'b0, 1'b0, 1'b1, 1'b1, 4'd0, 32'h0, 32'h0, epc, "mret new_pc");
        check_value("mret mstatus_mie_up", mstatus_mie_up, 1'b1);
        csr_read(csr_addr_mstatus, mstatus_mpp_bits | 32'h88, 1'b0, "mstatus after mret");
        check_value("mstatus_mie_up after mret", mstatus_mie_up, 1'b0);
        // Set mie and clear mpie so that mret has to change both fields
        csr_write(csr_addr_mstatus, csr_cmd_write, 32'h8, 1'b0, "mstatus mpie off");
        drive_event(1'b0, 1'b0, 1'b1, 1'b1, 4'd0, 32'h0, 32'h0, epc, "second mret new_pc");
        csr_read(csr_addr_mstatus, mstatus_mpp_bits | 32'h80, 1'b0,
                 "mstatus after second mret");
    endtask

    task automatic test_counters();
        logic [31:0] start;
        logic [31:0] stop;
        logic [31:0] v;
        logic        b;
        int          pulses;
        pulses = 0;
        read_value(csr_addr_instret, start);
        for (int i = 0; i < 16; i++) begin
            next_cycle();
            next_bit(b);
            instret_nexc = b;
            pulses += b;
        end
        read_value(csr_addr_instret, stop);
        check_value("instret pulses", stop, start + pulses);
        next_random(v);
        csr_write(csr_addr_mcycle, csr_cmd_write, v, 1'b0, "mcycle write");
        csr_read(csr_addr_cycle, v, 1'b0, "cycle right after write");
        csr_read(csr_addr_cycle, v + 32'd1, 1'b0, "cycle one edge later");
        next_random(v);
        csr_write(csr_addr_minstreth, csr_cmd_write, v, 1'b0, "minstreth write");
        csr_read(csr_addr_instreth, v, 1'b0, "instreth readback");
    endtask

    // Main sequence ----------------
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        r_req        = 1'b0;
        w_req        = 1'b0;
        rw_addr      = '0;
        w_cmd        = csr_cmd_none;
        w_data       = '0;
        evt          = '0;
        curr_pc      = '0;
        next_pc      = '0;
        instret_nexc = 1'b0;
        ext_irq      = 1'b0;
        soft_irq     = 1'b0;
        timer_irq    = 1'b0;
        fuse_mhartid = 32'h0000_0005;
        lfsr_state   = 32'h4ff9;
        mismatches   = 0;
        failures     = 0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
        test_reset();
        test_access();
        test_exception();
        test_interrupt(irq_epc);
        test_mret(irq_epc);
        test_counters();
        next_cycle();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- project.f
src/csr_pkg.sv
src/csr_access.sv
src/csr_trap.sv
src/csr_counter.sv
src/csr_unit.sv
sim/tb_csr_unit.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - src/csr_pkg.sv
  - src/csr_access.sv
  - src/csr_trap.sv
  - src/csr_counter.sv
  - src/csr_unit.sv
  - target: simulation
    files:
      - sim/tb_csr_unit.sv
